// ==== verilog.f ====
+incdir+rtl
rtl/histDataPkg.sv
rtl/histCtrlPkg.sv
rtl/histCounter.sv
rtl/histFsm.sv
rtl/binRam.sv
rtl/binIncrement.sv
rtl/histTop.sv
sim/histTb.sv

// ==== Bender.yml ====
package:
  name: hist_accumulator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/histDataPkg.sv
      - rtl/histCtrlPkg.sv
      - rtl/histCounter.sv
      - rtl/histFsm.sv
      - rtl/binRam.sv
      - rtl/binIncrement.sv
      - rtl/histTop.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/histTb.sv

// ==== sim/histTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hist_config.svh"

module histTb;

    import histDataPkg::*;

    localparam int BinNum       = 1 << `HIST_BIN_W;
    localparam int CountMax     = (1 << `HIST_COUNT_W) - 1;
    localparam int LowW         = `HIST_SAMPLE_W - `HIST_BIN_W;
    localparam int ClearCycles  = BinNum; // one zero write per bin
    localparam int IdleCycles   = 8;
    localparam int FrameTimeout = 8000;
    localparam int FrameNum     = 5;

    localparam logic [1:0] KindSingle = 2'd0;
    localparam logic [1:0] KindRamp   = 2'd1;
    localparam logic [1:0] KindRandom = 2'd2;
    localparam logic [1:0] KindSparse = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        binIdxT     fixedBin;
        logic [7:0] validPct; // chance of sampleValid per cycle
    } frameRowS;

    logic     clk;
    logic     res;
    logic     start;
    logic     sampleValid;
    sampleT   sample;
    logic     busy;
    binCountS binOut;
    logic     binOutValid;
    logic     done;

    frameRowS frameTable [FrameNum];
    int       expCount [BinNum]; // reference histogram
    int       errorCount;
    int       testsRun;
    int       testsFailed;
    logic     timedOut;

    histTop histTop_i (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .sample      (sample),
        .busy        (busy),
        .binOut      (binOut),
        .binOutValid (binOutValid),
        .done        (done)
    );

    always #4 clk = ~clk;

    function automatic sampleT makeSample(input frameRowS row, input int rampIdx);
        binIdxT          bin;
        logic [LowW-1:0] low;
        low = LowW'($urandom);
        case (row.kind)
            KindSingle: bin = row.fixedBin;
            KindRamp:   bin = binIdxT'(rampIdx);
            KindSparse: bin = ($urandom % 2 == 0) ? row.fixedBin
                                                  : row.fixedBin + binIdxT'(BinNum / 2);
            default:    bin = binIdxT'($urandom);
        endcase
        return {bin, low};
    endfunction

    function automatic string kindName(input logic [1:0] kind);
        case (kind)
            KindSingle: return "single";
            KindRamp:   return "ramp";
            KindSparse: return "sparse";
            default:    return "random";
        endcase
    endfunction

    task automatic checkResetState();
        int errs;
        int i;
        errs = 0;
        for (i = 0; i < 4; i++) begin
            @(posedge clk);
            if (busy !== 1'b0 || done !== 1'b0 || binOutValid !== 1'b0) begin
                $display("[ERROR] busy/done/binOutValid: got 0x%0h/0x%0h/0x%0h expected 0x0",
                         busy, done, binOutValid);
                errs++;
            end
        end
        testsRun++;
        if (errs > 0) testsFailed++;
        errorCount += errs;
        $display("Reset state check: %0d errors", errs);
    endtask

    task automatic runFrame(input int idx);
        frameRowS row;
        int       errs;
        int       accepted;
        int       busyCycle;
        int       strobeIdx;
        int       rampIdx;
        int       cyc;
        int       b;
        logic     prevValid;
        logic     finished;
        logic     drvValid;
        row = frameTable[idx];
        errs = 0;
        accepted = 0;
        busyCycle = 0;
        strobeIdx = 0;
        rampIdx = 0;
        prevValid = 1'b0;
        finished = 1'b0;
        for (b = 0; b < BinNum; b++) expCount[b] = 0;
        // valid samples while idle must not reach the bins
        for (cyc = 0; cyc < IdleCycles; cyc++) begin
            @(posedge clk);
            if (busy !== 1'b0) begin
                $display("[ERROR] busy: got 0x%0h expected 0x0", busy);
                errs++;
            end
            sampleValid <= 1'b1;
            sample      <= makeSample(row, cyc);
        end
        @(posedge clk);
        start <= 1'b1;
        cyc = 0;
        while (!finished && !timedOut) begin
            @(posedge clk);
            if (cyc == 0 && busy !== 1'b0) begin
                $display("[ERROR] busy: got 0x%0h expected 0x0", busy);
                errs++;
            end
            if (cyc == 1 && busy !== 1'b1) begin
                $display("[ERROR] busy: got 0x%0h expected 0x1", busy);
                errs++;
            end
            if (busy === 1'b1) begin
                // first busy cycles belong to the clear sweep
                if (busyCycle >= ClearCycles && sampleValid && accepted < `HIST_SAMPLE_NUM) begin
                    b = sample[`HIST_SAMPLE_W-1 -: `HIST_BIN_W];
                    if (expCount[b] < CountMax) expCount[b]++;
                    accepted++;
                end
                busyCycle++;
            end
            if (binOutValid === 1'b1) begin
                if (strobeIdx > 0 && !prevValid) begin
                    $display("Frame %0d: gap between readout strobes", idx);
                    errs++;
                end
                if (strobeIdx >= BinNum) begin
                    $display("Frame %0d: more readout strobes than bins", idx);
                    errs++;
                end else begin
                    if (binOut.bin !== binIdxT'(strobeIdx)) begin
                        $display("[ERROR] binOut.bin: got 0x%0h expected 0x%0h",
                                 binOut.bin, strobeIdx);
                        errs++;
                    end
                    if (binOut.count !== countT'(expCount[strobeIdx])) begin
                        $display("[ERROR] binOut.count bin 0x%0h: got 0x%0h expected 0x%0h",
                                 strobeIdx, binOut.count, expCount[strobeIdx]);
                        errs++;
                    end
                end
                strobeIdx++;
            end
            if (done === 1'b1) begin
                if (strobeIdx != BinNum || !prevValid) begin
                    $display("Frame %0d: done did not follow the last of %0d strobes (saw %0d)",
                             idx, BinNum, strobeIdx);
                    errs++;
                end
                if (busy !== 1'b0) begin
                    $display("[ERROR] busy: got 0x%0h expected 0x0", busy);
                    errs++;
                end
                finished = 1'b1;
            end
            prevValid = (binOutValid === 1'b1);
            start <= 1'b0;
            drvValid = ($urandom % 100) < row.validPct;
            sampleValid <= drvValid;
            sample      <= makeSample(row, rampIdx);
            if (drvValid) rampIdx++;
            cyc++;
            if (!finished && cyc >= FrameTimeout) begin
                $display("Frame %0d: no done within %0d cycles, stopping", idx, FrameTimeout);
                errs++;
                timedOut = 1'b1;
            end
        end
        sampleValid <= 1'b0;
        testsRun++;
        if (errs > 0) testsFailed++;
        errorCount += errs;
        $display("Frame %0d (%s, bin %0d, %0d%% valid): %0d samples, %0d cycles, %0d errors",
                 idx, kindName(row.kind), row.fixedBin, row.validPct, accepted, cyc, errs);
    endtask

    initial begin
        int f;
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        void'($urandom(61051));
        frameTable[0] = '{kind: KindRamp,   fixedBin: binIdxT'(0), validPct: 8'd100};
        frameTable[1] = '{kind: KindSingle, fixedBin: binIdxT'(5), validPct: 8'd100};
        frameTable[2] = '{kind: KindRandom, fixedBin: binIdxT'(0), validPct: 8'd60};
        frameTable[3] = '{kind: KindSparse, fixedBin: binIdxT'(2), validPct: 8'd25};
        frameTable[4] = '{kind: KindRandom, fixedBin: binIdxT'(0), validPct: 8'd100};
        repeat (16) @(posedge clk);
        res <= 1'b1;
        checkResetState();
        for (f = 0; f < FrameNum && !timedOut; f++) begin
            runFrame(f);
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/histTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTop (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  logic                  sampleValid,
    input  histDataPkg::sampleT   sample,
    output logic                  busy,
    output histDataPkg::binCountS binOut,
    output logic                  binOutValid,
    output logic                  done
);

    import histDataPkg::*;
    import histCtrlPkg::*;

    sweepCmdS sweepCmd;
    binIdxT   sweepAddr;
    logic     sweepLast;
    logic     samplesDone;
    logic     sampleAccept;
    logic     accEnable;
    countT    rdData;
    memWriteS clrWrite;
    memWriteS incWrite;
    memWriteS ramWrite;
    memReadS  outRead;
    memReadS  incRead;
    memReadS  ramRead;

    // FSM owns the RAM ports only in clear and readout
    assign ramWrite = clrWrite.en ? clrWrite : incWrite;
    assign ramRead  = outRead.en ? outRead : incRead;

    histFsm histFsm_i (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .samplesDone (samplesDone),
        .sweepAddr   (sweepAddr),
        .sweepLast   (sweepLast),
        .rdData      (rdData),
        .sweepCmd    (sweepCmd),
        .clrWrite    (clrWrite),
        .outRead     (outRead),
        .accEnable   (accEnable),
        .busy        (busy),
        .binOut      (binOut),
        .binOutValid (binOutValid),
        .done        (done)
    );

    histCounter histCounter_i (
        .clk          (clk),
        .res          (res),
        .cmd          (sweepCmd),
        .sampleAccept (sampleAccept),
        .sweepAddr    (sweepAddr),
        .sweepLast    (sweepLast),
        .samplesDone  (samplesDone)
    );

    binRam binRam_i (
        .clk    (clk),
        .wr     (ramWrite),
        .rd     (ramRead),
        .rdData (rdData)
    );

    binIncrement binIncrement_i (
        .clk          (clk),
        .res          (res),
        .accEnable    (accEnable),
        .sampleValid  (sampleValid),
        .sample       (sample),
        .rdData       (rdData),
        .rd           (incRead),
        .wr           (incWrite),
        .sampleAccept (sampleAccept)
    );

endmodule

`default_nettype wire

// ==== rtl/binIncrement.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hist_config.svh"

module binIncrement (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  accEnable,
    input  logic                  sampleValid,
    input  histDataPkg::sampleT   sample,
    input  histDataPkg::countT    rdData,
    output histCtrlPkg::memReadS  rd,
    output histCtrlPkg::memWriteS wr,
    output logic                  sampleAccept
);

    import histDataPkg::*;

    logic   accept;
    binIdxT bin0;     // stage 0 bin
    binIdxT bin1;     // stage 1 bin
    logic   valid1;
    logic   fwdHit;   // stage 1 must use the last written count
    countT  fwdData;
    countT  base;
    countT  wrCount;

    assign accept = accEnable && sampleValid;

    // bin = top bits of the sample
    assign bin0 = sample[`HIST_SAMPLE_W-1 -: `HIST_BIN_W];

    // stage 0 reads the current count
    assign rd = '{en: accept, addr: bin0};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            valid1 <= 1'b0;
            fwdHit <= 1'b0;
        end else begin
            valid1 <= accept;
            // RAM returns stale data when stage 1 writes the same bin
            fwdHit <= accept && valid1 && (bin0 == bin1);
        end
    end

    always_ff @(posedge clk) begin
        bin1    <= bin0;
        fwdData <= wrCount;
    end

    assign base = fwdHit ? fwdData : rdData;

    // saturate instead of wrapping
    assign wrCount = (base == '1) ? base : base + countT'(1);

    // stage 1 writes back
    assign wr = '{en: valid1, addr: bin1, data: wrCount};

    assign sampleAccept = accept;

endmodule

`default_nettype wire

// ==== rtl/binRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hist_config.svh"

module binRam (
    input  logic                  clk,
    input  histCtrlPkg::memWriteS wr,
    input  histCtrlPkg::memReadS  rd,
    output histDataPkg::countT    rdData
);

    import histDataPkg::*;

    localparam int BinNum = 1 << `HIST_BIN_W;

    countT mem [BinNum];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, same-address write in the same cycle returns old data
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdData <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/histFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module histFsm (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  start,
    input  logic                  samplesDone,
    input  histDataPkg::binIdxT   sweepAddr,
    input  logic                  sweepLast,
    input  histDataPkg::countT    rdData,
    output histCtrlPkg::sweepCmdS sweepCmd,
    output histCtrlPkg::memWriteS clrWrite,
    output histCtrlPkg::memReadS  outRead,
    output logic                  accEnable,
    output logic                  busy,
    output histDataPkg::binCountS binOut,
    output logic                  binOutValid,
    output logic                  done
);

    import histDataPkg::*;
    import histCtrlPkg::*;

    histStateE state;
    histStateE stateNext;
    logic      drainCnt;   // second drain cycle
    logic      lastStrobe;
    logic      startOk;
    binIdxT    binQ;       // read address, aligned with RAM data

    // a new frame only once the previous one has fully signalled done
    assign startOk = (state == stIdle) && start && !busy;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:    if (startOk) stateNext = stClear;
            stClear:   if (sweepLast) stateNext = stAccum;
            stAccum:   if (samplesDone) stateNext = stDrain;
            stDrain:   if (drainCnt) stateNext = stReadout;
            stReadout: if (sweepLast) stateNext = stIdle;
            default:   stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= stIdle;
            drainCnt    <= 1'b0;
            busy        <= 1'b0;
            binOutValid <= 1'b0;
            done        <= 1'b0;
        end else begin
            state       <= stateNext;
            drainCnt    <= (state == stDrain);
            binOutValid <= (state == stReadout); // RAM read latency
            done        <= lastStrobe;
            if (startOk) begin
                busy <= 1'b1;
            end else if (lastStrobe) begin
                busy <= 1'b0; // drops together with done
            end
        end
    end

    always_ff @(posedge clk) begin
        binQ <= sweepAddr;
    end

    // final strobe is the one seen after readout has left
    assign lastStrobe = binOutValid && (state != stReadout);

    assign sweepCmd = '{
        sweepClr:  (state == stIdle),
        sweepRun:  (state == stClear) || (state == stReadout),
        sampleClr: (state == stIdle)
    };

    // zero fill during clear
    assign clrWrite = '{en: (state == stClear), addr: sweepAddr, data: '0};

    // ascending sweep during readout
    assign outRead = '{en: (state == stReadout), addr: sweepAddr};

    assign accEnable = (state == stAccum);

    assign binOut = '{bin: binQ, count: rdData};

endmodule

`default_nettype wire

// ==== rtl/histCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hist_config.svh"

module histCounter (
    input  logic                  clk,
    input  logic                  res,
    input  histCtrlPkg::sweepCmdS cmd,
    input  logic                  sampleAccept,
    output histDataPkg::binIdxT   sweepAddr,
    output logic                  sweepLast,
    output logic                  samplesDone
);

    import histDataPkg::*;

    localparam logic [`HIST_SWEEP_W-1:0] LastSample = `HIST_SWEEP_W'(`HIST_SAMPLE_NUM - 1);

    logic [`HIST_SWEEP_W-1:0] sampleCnt;

    // bin sweep, shared by clear and readout
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweepAddr <= '0;
        end else if (cmd.sweepClr) begin
            sweepAddr <= '0;
        end else if (cmd.sweepRun) begin
            sweepAddr <= sweepAddr + binIdxT'(1); // wraps to bin 0 after the last
        end
    end

    assign sweepLast = (sweepAddr == '1);

    // accepted samples in this frame
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sampleCnt <= '0;
        end else if (cmd.sampleClr) begin
            sampleCnt <= '0;
        end else if (sampleAccept) begin
            sampleCnt <= sampleCnt + 1'b1;
        end
    end

    // high in the cycle the final sample of the frame is taken
    assign samplesDone = sampleAccept && (sampleCnt == LastSample);

endmodule

`default_nettype wire

// ==== rtl/histCtrlPkg.sv ====
`default_nettype none

package histCtrlPkg;

    // frame phases
    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stClear   = 3'd1,
        stAccum   = 3'd2,
        stDrain   = 3'd3,
        stReadout = 3'd4
    } histStateE;

    // bin RAM write port
    typedef struct packed {
        logic                en;
        histDataPkg::binIdxT addr;
        histDataPkg::countT  data;
    } memWriteS;

    // bin RAM read port
    typedef struct packed {
        logic                en;
        histDataPkg::binIdxT addr;
    } memReadS;

    // FSM to counter steering
    typedef struct packed {
        logic sweepClr;  // zero the bin sweep
        logic sweepRun;  // step the bin sweep
        logic sampleClr; // zero the accepted count
    } sweepCmdS;

endpackage

`default_nettype wire

// ==== rtl/histDataPkg.sv ====
`default_nettype none

`include "hist_config.svh"

package histDataPkg;

    // raw detector sample
    typedef logic [`HIST_SAMPLE_W-1:0] sampleT;

    // bin index, top bits of a sample
    typedef logic [`HIST_BIN_W-1:0] binIdxT;

    // per-bin count
    typedef logic [`HIST_COUNT_W-1:0] countT;

    // one readout result
    typedef struct packed {
        binIdxT bin;
        countT  count;
    } binCountS;

endpackage

`default_nettype wire

// ==== rtl/hist_config.svh ====
`ifndef HIST_CONFIG_SVH
`define HIST_CONFIG_SVH

// sample and bin geometry
`define HIST_SAMPLE_W 12
`define HIST_BIN_W 4 // 16 bins, top bits of the sample

// count range, saturates at all-ones
`define HIST_COUNT_W 8

// valid samples taken per frame, above the count max on purpose
`define HIST_SAMPLE_NUM 300

// accepted-sample counter width
`define HIST_SWEEP_W 16

`endif
